/* llc_pkg.sv */
`default_nettype none

package llc_pkg;

    localparam int LLC_WAYS       = 2;
    localparam int LLC_SETS       = 16;
    localparam int WORDS_PER_LINE = 4;
    localparam int ADDR_W         = 12;  // word address
    localparam int TAG_W          = 6;
    localparam int SET_W          = 4;
    localparam int OFF_W          = 2;
    localparam int ID_W           = 4;
    localparam int WORD_W         = 32;
    localparam int WAY_W          = $clog2(LLC_WAYS);

    typedef logic [WORD_W-1:0]                llc_word_t;
    typedef llc_word_t [WORDS_PER_LINE-1:0]   llc_line_t;
    typedef logic [TAG_W-1:0]                 llc_tag_t;
    typedef logic [SET_W-1:0]                 llc_set_t;
    typedef logic [OFF_W-1:0]                 llc_off_t;
    typedef logic [WAY_W-1:0]                 llc_way_t;
    typedef logic [TAG_W+SET_W-1:0]           llc_line_addr_t;  // tag then set
    typedef logic [ID_W-1:0]                  llc_id_t;

    typedef enum logic {
        INVALID = 1'b0,
        VALID   = 1'b1
    } llc_state_t;

    typedef enum logic [1:0] {
        LLC_READ  = 2'd0,
        LLC_WRITE = 2'd1,
        LLC_FLUSH = 2'd2
    } llc_op_t;

    // work handed from the input decoder to the phase FSM
    typedef enum logic [1:0] {
        ACT_NONE  = 2'd0,
        ACT_RST   = 2'd1,
        ACT_FLUSH = 2'd2,
        ACT_REQ   = 2'd3
    } llc_action_t;

    typedef struct packed {
        llc_tag_t tag;
        llc_set_t set;
        llc_off_t off;
    } llc_addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] word;
        llc_addr_fields_t  f;
    } llc_addr_u;

    typedef struct packed {
        llc_op_t   op;
        llc_id_t   id;
        llc_addr_u addr;
        llc_word_t wdata;
    } llc_req_t;

    typedef struct packed {
        llc_id_t   id;
        llc_word_t rdata;
    } llc_rsp_t;

    typedef struct packed {
        logic           write;
        llc_line_addr_t line_addr;
        llc_line_t      line;
    } llc_mem_req_t;

    typedef struct packed {
        llc_line_t line;  // ignored for a writeback
    } llc_mem_rsp_t;

    typedef struct packed {
        llc_tag_t   tag;
        llc_state_t state;
        logic       dirty;
        llc_line_t  line;
    } llc_way_data_t;

endpackage

`default_nettype wire

/* llc_localmem.sv */
`default_nettype none

module llc_localmem (
    input  wire logic                                       clk,
    input  wire logic                                       rst,
    input  wire logic                                       rd_en_i,
    input  wire llc_pkg::llc_set_t                          rd_set_i,
    output llc_pkg::llc_way_data_t [llc_pkg::LLC_WAYS-1:0]  rd_data_o,
    output llc_pkg::llc_way_t                               rd_evict_way_o,
    input  wire logic                                       wr_en_i,
    input  wire logic                                       wr_all_i,
    input  wire llc_pkg::llc_way_t                          wr_way_i,
    input  wire llc_pkg::llc_set_t                          wr_set_i,
    input  wire llc_pkg::llc_way_data_t                     wr_data_i,
    input  wire logic                                       wr_evict_en_i,
    input  wire llc_pkg::llc_way_t                          wr_evict_way_i
);
    import llc_pkg::*;

    llc_tag_t   tag_mem   [LLC_WAYS][LLC_SETS];
    llc_state_t state_mem [LLC_WAYS][LLC_SETS];
    logic       dirty_mem [LLC_WAYS][LLC_SETS];
    llc_line_t  line_mem  [LLC_WAYS][LLC_SETS];
    llc_way_t   evict_mem [LLC_SETS];  // next victim per set

    // one way, or all ways at once for reset and flush steps
    always_ff @(posedge clk) begin
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (wr_en_i && (wr_all_i || wr_way_i == llc_way_t'(w))) begin
                tag_mem[w][wr_set_i]   <= wr_data_i.tag;
                state_mem[w][wr_set_i] <= wr_data_i.state;
                dirty_mem[w][wr_set_i] <= wr_data_i.dirty;
                line_mem[w][wr_set_i]  <= wr_data_i.line;
            end
        end
        if (wr_evict_en_i) begin
            evict_mem[wr_set_i] <= wr_evict_way_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                rd_data_o[w].tag   <= tag_mem[w][rd_set_i];
                rd_data_o[w].state <= state_mem[w][rd_set_i];
                rd_data_o[w].dirty <= dirty_mem[w][rd_set_i];
                rd_data_o[w].line  <= line_mem[w][rd_set_i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rd_evict_way_o <= '0;
        end else if (rd_en_i) begin
            rd_evict_way_o <= evict_mem[rd_set_i];
        end
    end

endmodule

`default_nettype wire

/* llc_input_decoder.sv */
`default_nettype none

module llc_input_decoder (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire llc_pkg::llc_req_t    req_i,
    input  wire logic                 req_valid_i,
    output logic                      req_ready_o,
    input  wire logic                 decode_en_i,
    input  wire logic                 update_en_i,
    output llc_pkg::llc_req_t         cur_req_o,
    output llc_pkg::llc_action_t      action_o,
    output llc_pkg::llc_set_t         set_o
);
    import llc_pkg::*;

    llc_req_t req_q;
    logic     busy_q;         // client request in flight
    logic     rst_stall_q;
    logic     flush_stall_q;
    llc_set_t walk_set_q;     // set of the reset or flush walk
    logic     accept;
    logic     walk_last;

    assign req_ready_o = decode_en_i && !rst_stall_q && !flush_stall_q && !busy_q;
    assign accept      = req_valid_i && req_ready_o;
    assign walk_last   = (walk_set_q == llc_set_t'(LLC_SETS - 1));

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall_q   <= 1'b1;  // walk all sets before the first request
            flush_stall_q <= 1'b0;
            busy_q        <= 1'b0;
            walk_set_q    <= '0;
        end else begin
            if (accept) begin
                if (req_i.op == LLC_FLUSH) begin
                    flush_stall_q <= 1'b1;
                end else begin
                    busy_q <= 1'b1;
                end
            end
            if (update_en_i) begin
                if (rst_stall_q || flush_stall_q) begin
                    walk_set_q <= walk_set_q + 1'b1;  // wraps back to set 0
                    if (walk_last) begin
                        rst_stall_q   <= 1'b0;
                        flush_stall_q <= 1'b0;
                    end
                end else begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        action_o = ACT_NONE;
        set_o    = req_q.addr.f.set;
        if (rst_stall_q) begin
            action_o = ACT_RST;
            set_o    = walk_set_q;
        end else if (flush_stall_q) begin
            action_o = ACT_FLUSH;
            set_o    = walk_set_q;
        end else if (busy_q) begin
            action_o = ACT_REQ;
        end
        cur_req_o            = req_q;
        cur_req_o.addr.f.set = set_o;  // flush steps carry the walk set
    end

endmodule

`default_nettype wire

/* llc_process.sv */
`default_nettype none

module llc_process (
    input  wire logic                                           clk,
    input  wire logic                                           rst,
    input  wire logic                                           process_en_i,
    input  wire llc_pkg::llc_action_t                           action_i,
    input  wire llc_pkg::llc_req_t                              cur_req_i,
    input  wire llc_pkg::llc_way_data_t [llc_pkg::LLC_WAYS-1:0] bufs_i,
    input  wire llc_pkg::llc_way_t                              evict_way_i,
    output logic                                                buf_wr_en_o,
    output llc_pkg::llc_way_t                                   buf_wr_way_o,
    output llc_pkg::llc_way_data_t                              buf_wr_data_o,
    output llc_pkg::llc_way_t                                   new_evict_way_o,
    output logic                                                process_done_o,
    output llc_pkg::llc_rsp_t                                   rsp_o,
    output logic                                                rsp_valid_o,
    input  wire logic                                           rsp_ready_i,
    output llc_pkg::llc_mem_req_t                               mem_req_o,
    output logic                                                mem_req_valid_o,
    input  wire logic                                           mem_req_ready_i,
    input  wire llc_pkg::llc_mem_rsp_t                          mem_rsp_i,
    input  wire logic                                           mem_rsp_valid_i,
    output logic                                                mem_rsp_ready_o
);
    import llc_pkg::*;

    typedef enum logic [2:0] {
        P_LOOK,
        P_MREQ,
        P_MRSP,
        P_RSP,
        P_DONE
    } pstate_t;

    pstate_t  state_q;
    llc_way_t way_q;     // way under writeback or fill
    logic     wb_q;      // memory op in flight is a writeback
    logic     alloc_q;   // a line was allocated for this request
    logic     hit;
    llc_way_t hit_way;
    logic     any_dirty;
    llc_way_t dirty_way;
    llc_way_t sel_way;
    logic     victim_dirty;
    logic     do_wb;
    logic     last_set;
    logic     look_done;
    logic     look;
    llc_tag_t req_tag;
    llc_set_t req_set;
    llc_off_t req_off;

    assign req_tag = cur_req_i.addr.f.tag;
    assign req_set = cur_req_i.addr.f.set;
    assign req_off = cur_req_i.addr.f.off;

    // lowest way wins
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        any_dirty = 1'b0;
        dirty_way = '0;
        for (int w = LLC_WAYS - 1; w >= 0; w--) begin
            if (bufs_i[w].state == VALID && bufs_i[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
            if (bufs_i[w].state == VALID && bufs_i[w].dirty) begin
                any_dirty = 1'b1;
                dirty_way = llc_way_t'(w);
            end
        end
    end

    assign sel_way      = (action_i == ACT_FLUSH) ? dirty_way : (hit ? hit_way : evict_way_i);
    assign victim_dirty = bufs_i[evict_way_i].state == VALID && bufs_i[evict_way_i].dirty;
    assign do_wb        = (action_i == ACT_FLUSH) || victim_dirty;
    assign last_set     = (req_set == llc_set_t'(LLC_SETS - 1));
    assign look         = (state_q == P_LOOK) && process_en_i;
    assign look_done    = (action_i != ACT_REQ) &&
                          !(action_i == ACT_FLUSH && (any_dirty || last_set));

    assign process_done_o  = (state_q == P_DONE) || (look && look_done);
    assign buf_wr_way_o    = (state_q == P_LOOK) ? sel_way : way_q;
    assign new_evict_way_o = alloc_q ? evict_way_i + 1'b1 : evict_way_i;  // round robin
    assign mem_rsp_ready_o = (state_q == P_MRSP);

    always_comb begin
        buf_wr_en_o   = 1'b0;
        buf_wr_data_o = bufs_i[buf_wr_way_o];
        if (look && action_i == ACT_REQ && hit && cur_req_i.op == LLC_WRITE) begin
            buf_wr_en_o                  = 1'b1;
            buf_wr_data_o.line[req_off]  = cur_req_i.wdata;
            buf_wr_data_o.dirty          = 1'b1;
        end else if (state_q == P_MRSP && mem_rsp_valid_i) begin
            buf_wr_en_o         = 1'b1;
            buf_wr_data_o.dirty = 1'b0;  // written back, or a fresh fill
            if (!wb_q) begin
                buf_wr_data_o.tag   = req_tag;
                buf_wr_data_o.state = VALID;
                buf_wr_data_o.line  = mem_rsp_i.line;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q         <= P_LOOK;
            way_q           <= '0;
            wb_q            <= 1'b0;
            alloc_q         <= 1'b0;
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
        end else begin
            case (state_q)
                P_LOOK: begin
                    if (!process_en_i) begin
                        alloc_q <= 1'b0;  // held through update for the pointer write
                    end else if (action_i == ACT_REQ && hit) begin
                        rsp_valid_o <= 1'b1;
                        state_q     <= P_RSP;
                    end else if (action_i == ACT_REQ || (action_i == ACT_FLUSH && any_dirty)) begin
                        way_q           <= sel_way;
                        wb_q            <= do_wb;
                        mem_req_valid_o <= 1'b1;
                        state_q         <= P_MREQ;
                    end else if (action_i == ACT_FLUSH && last_set) begin
                        rsp_valid_o <= 1'b1;  // one answer for the whole flush
                        state_q     <= P_RSP;
                    end
                end
                P_MREQ: begin
                    if (mem_req_ready_i) begin
                        mem_req_valid_o <= 1'b0;
                        state_q         <= P_MRSP;
                    end
                end
                P_MRSP: begin
                    if (mem_rsp_valid_i) begin
                        alloc_q <= alloc_q || !wb_q;
                        state_q <= P_LOOK;  // look again with the updated buffer
                    end
                end
                P_RSP: begin
                    if (rsp_ready_i) begin
                        rsp_valid_o <= 1'b0;
                        state_q     <= P_DONE;
                    end
                end
                default: state_q <= P_LOOK;
            endcase
        end
    end

    // payloads only change in P_LOOK, while both valids are low
    always_ff @(posedge clk) begin
        if (look) begin
            rsp_o.id <= cur_req_i.id;
            if (action_i == ACT_FLUSH) begin
                rsp_o.rdata <= '0;
            end else if (cur_req_i.op == LLC_WRITE) begin
                rsp_o.rdata <= cur_req_i.wdata;
            end else begin
                rsp_o.rdata <= bufs_i[hit_way].line[req_off];
            end
            mem_req_o.write     <= do_wb;
            mem_req_o.line_addr <= do_wb ? {bufs_i[sel_way].tag, req_set}
                                         : cur_req_i.addr.word[ADDR_W-1:OFF_W];
            mem_req_o.line      <= bufs_i[sel_way].line;
        end
    end

endmodule

`default_nettype wire

/* llc.sv */
`default_nettype none

module llc (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire llc_pkg::llc_req_t      req_i,
    input  wire logic                   req_valid_i,
    output logic                        req_ready_o,
    output llc_pkg::llc_rsp_t           rsp_o,
    output logic                        rsp_valid_o,
    input  wire logic                   rsp_ready_i,
    output llc_pkg::llc_mem_req_t       mem_req_o,
    output logic                        mem_req_valid_o,
    input  wire logic                   mem_req_ready_i,
    input  wire llc_pkg::llc_mem_rsp_t  mem_rsp_i,
    input  wire logic                   mem_rsp_valid_i,
    output logic                        mem_rsp_ready_o
);
    import llc_pkg::*;

    typedef enum logic [1:0] {
        DECODE  = 2'b00,
        READ    = 2'b01,
        PROCESS = 2'b11,
        UPDATE  = 2'b10
    } phase_t;

    phase_t                       state_q;
    phase_t                       state_d;
    logic                         decode_en;
    logic                         process_en;
    logic                         update_en;
    llc_req_t                     cur_req;
    llc_action_t                  action;
    llc_set_t                     cur_set;
    llc_way_data_t [LLC_WAYS-1:0] rd_data;
    llc_way_t                     rd_evict_way;
    llc_way_data_t [LLC_WAYS-1:0] bufs_q;
    llc_way_t                     evict_buf_q;
    logic                         buf_wr_en;
    llc_way_t                     buf_wr_way;
    llc_way_data_t                buf_wr_data;
    llc_way_t                     new_evict_way;
    logic                         process_done;
    logic                         wr_en;
    logic                         wr_all;
    llc_way_data_t                wr_data;
    logic                         wr_evict_en;
    llc_way_t                     wr_evict_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= DECODE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            DECODE:  if (action != ACT_NONE) state_d = READ;  // idle until work shows up
            READ:    state_d = PROCESS;
            PROCESS: if (process_done) state_d = UPDATE;
            UPDATE:  state_d = DECODE;
            default: state_d = DECODE;
        endcase
    end

    assign decode_en  = (state_q == DECODE);
    assign process_en = (state_q == PROCESS);
    assign update_en  = (state_q == UPDATE);

    llc_input_decoder i_input_decoder (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .decode_en_i (decode_en),
        .update_en_i (update_en),
        .cur_req_o   (cur_req),
        .action_o    (action),
        .set_o       (cur_set)
    );

    llc_localmem i_localmem (
        .clk            (clk),
        .rst            (rst),
        .rd_en_i        (decode_en && action != ACT_NONE),
        .rd_set_i       (cur_set),
        .rd_data_o      (rd_data),
        .rd_evict_way_o (rd_evict_way),
        .wr_en_i        (wr_en),
        .wr_all_i       (wr_all),
        .wr_way_i       (buf_wr_way),
        .wr_set_i       (cur_set),
        .wr_data_i      (wr_data),
        .wr_evict_en_i  (wr_evict_en),
        .wr_evict_way_i (wr_evict_way)
    );

    // way buffers: loaded in READ, edited in place by process
    always_ff @(posedge clk) begin
        if (state_q == READ) begin
            bufs_q      <= rd_data;
            evict_buf_q <= rd_evict_way;
        end else if (buf_wr_en) begin
            bufs_q[buf_wr_way] <= buf_wr_data;
        end
    end

    llc_process i_process (
        .clk             (clk),
        .rst             (rst),
        .process_en_i    (process_en),
        .action_i        (action),
        .cur_req_i       (cur_req),
        .bufs_i          (bufs_q),
        .evict_way_i     (evict_buf_q),
        .buf_wr_en_o     (buf_wr_en),
        .buf_wr_way_o    (buf_wr_way),
        .buf_wr_data_o   (buf_wr_data),
        .new_evict_way_o (new_evict_way),
        .process_done_o  (process_done),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    // write back to the store in UPDATE
    always_comb begin
        wr_en        = update_en;
        wr_all       = (action != ACT_REQ);
        wr_data      = bufs_q[buf_wr_way];
        wr_evict_en  = 1'b0;
        wr_evict_way = new_evict_way;
        case (action)
            ACT_RST, ACT_FLUSH: begin
                wr_data      = '0;  // invalid and clean in every way
                wr_evict_en  = update_en && (action == ACT_RST);
                wr_evict_way = '0;
            end
            ACT_REQ: wr_evict_en = update_en;
            default: wr_en = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* llc_sva.sv */
`default_nettype none

module llc_sva (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic                  req_ready_i,
    input wire llc_pkg::llc_rsp_t     rsp_i,
    input wire logic                  rsp_valid_i,
    input wire logic                  rsp_ready_i,
    input wire llc_pkg::llc_mem_req_t mem_req_i,
    input wire logic                  mem_req_valid_i,
    input wire logic                  mem_req_ready_i,
    input wire logic                  mem_rsp_valid_i,
    input wire logic                  mem_rsp_ready_i
);
    import llc_pkg::*;

    int unsigned walk_cnt;
    logic        mem_pending;  // memory request sent, response not yet taken

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            walk_cnt    <= 0;
            mem_pending <= 1'b0;
        end else begin
            if (walk_cnt < LLC_SETS * 4) begin
                walk_cnt <= walk_cnt + 1;
            end
            if (mem_req_valid_i && mem_req_ready_i) begin
                mem_pending <= 1'b1;
            end else if (mem_rsp_valid_i && mem_rsp_ready_i) begin
                mem_pending <= 1'b0;
            end
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
        else $error("rsp_o dropped or changed before its transfer");

    mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else $error("mem_req_o dropped or changed before its transfer");

    ready_after_walk: assert property (@(posedge clk) disable iff (!rst)
        req_ready_i |-> walk_cnt >= LLC_SETS * 4)
        else $error("req_ready_o high before the reset walk finished");

    one_mem_req: assert property (@(posedge clk) disable iff (!rst)
        mem_pending |-> !mem_req_valid_i)
        else $error("second memory request while a response is pending");

endmodule

bind llc llc_sva i_sva (
    .clk             (clk),
    .rst             (rst),
    .req_ready_i     (req_ready_o),
    .rsp_i           (rsp_o),
    .rsp_valid_i     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .mem_req_i       (mem_req_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_i (mem_rsp_ready_o)
);

`default_nettype wire

/* llc_tb.sv */
`default_nettype none

module llc_tb;
    import llc_pkg::*;

    localparam int NUM_OPS        = 400;
    localparam int FOOTPRINT      = 64;  // lines, twice the capacity
    localparam int MAX_FLUSHES    = 16;
    localparam int NUM_LINES      = 1 << (TAG_W + SET_W);
    localparam int NUM_WORDS      = 1 << ADDR_W;
    localparam int WALK_CYCLES    = LLC_SETS * 4;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 4 + WALK_CYCLES + MAX_FLUSHES * 300;

    logic         clk;
    logic         rst;
    llc_req_t     req_i;
    logic         req_valid_i;
    logic         req_ready_o;
    llc_rsp_t     rsp_o;
    logic         rsp_valid_o;
    logic         rsp_ready_i;
    llc_mem_req_t mem_req_o;
    logic         mem_req_valid_o;
    logic         mem_req_ready_i;
    llc_mem_rsp_t mem_rsp_i;
    logic         mem_rsp_valid_i;
    logic         mem_rsp_ready_o;

    llc_word_t      model_mem [NUM_WORDS];
    llc_line_t      mem_image [NUM_LINES];
    logic           need_fill [NUM_LINES];  // next access must fetch the line
    llc_line_addr_t cur_line;
    logic           seen_fill;
    logic           started;
    int unsigned    cycle_cnt = 0;
    int unsigned    rsp_cnt   = 0;
    int unsigned    wb_cnt    = 0;
    int unsigned    flush_cnt = 0;
    int unsigned    walk;
    llc_req_t       req;
    llc_rsp_t       exp_rsp;
    llc_rsp_t       got_rsp;
    string          name;

    llc i_dut (
        .clk             (clk),
        .rst             (rst),
        .req_i           (req_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .rsp_o           (rsp_o),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o)
    );

    // memory contents before any write, unique per word address
    function automatic llc_word_t init_word(int unsigned a);
        return {8'hA5, 12'(a), ~12'(a)};
    endfunction

    function automatic llc_line_t model_line(int unsigned l);
        llc_line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w] = model_mem[l * WORDS_PER_LINE + w];
        end
        return line;
    endfunction

    // four tags per set, so every set overflows its two ways
    function automatic llc_addr_u pick_addr();
        llc_addr_u   a;
        int unsigned k;
        k       = $urandom_range(FOOTPRINT - 1, 0);
        a.f.tag = llc_tag_t'((k / LLC_SETS) * 13 + 5);
        a.f.set = llc_set_t'(k % LLC_SETS);
        a.f.off = llc_off_t'($urandom_range(WORDS_PER_LINE - 1, 0));
        return a;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at cycle %0d", cycle_cnt);
    endtask

    task automatic check_rsp(input string test, input llc_rsp_t exp, input llc_rsp_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected id %0d data %h, actual id %0d data %h",
                                test, exp.id, exp.rdata, act.id, act.rdata));
        end
    endtask

    task automatic check_line(input string test, input llc_line_t exp, input llc_line_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERR %s expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic issue_req(input llc_req_t r);
        @(posedge clk);
        req_i       <= r;
        req_valid_i <= 1'b1;
        do begin
            @(negedge clk);
        end while (!req_ready_o);
        @(posedge clk);  // handshake edge
        req_valid_i <= 1'b0;
    endtask

    task automatic take_rsp(output llc_rsp_t r);
        do begin
            @(negedge clk);
        end while (!(rsp_valid_o && rsp_ready_i));
        r = rsp_o;
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, the run did not end within %0d cycles", cycle_cnt));
        end
    end

    initial begin
        rsp_ready_i = 1'b0;
        forever begin
            @(posedge clk);
            rsp_ready_i <= ($urandom_range(3, 0) != 0);  // low about a quarter of cycles
        end
    end

    always @(negedge clk) begin
        if (rsp_valid_o && rsp_ready_i) begin
            rsp_cnt <= rsp_cnt + 1;
        end
    end

    // memory responder, one request at a time
    initial begin
        llc_mem_req_t mreq;
        int unsigned  delay;
        mem_req_ready_i = 1'b0;
        mem_rsp_valid_i = 1'b0;
        mem_rsp_i       = '0;
        forever begin
            @(posedge clk);
            mem_req_ready_i <= ($urandom_range(3, 0) != 0);
            @(negedge clk);
            if (mem_req_valid_o && mem_req_ready_i) begin
                mreq = mem_req_o;
                if (!started) begin
                    abort_run("memory request issued before the first client request");
                end
                @(posedge clk);
                mem_req_ready_i <= 1'b0;
                if (mreq.write) begin
                    check_line($sformatf("writeback line %03h", mreq.line_addr),
                               model_line(mreq.line_addr), mreq.line);
                    mem_image[mreq.line_addr] = mreq.line;
                    wb_cnt++;
                    mem_rsp_i.line <= '0;
                end else begin
                    if (mreq.line_addr == cur_line) begin
                        seen_fill = 1'b1;
                    end
                    mem_rsp_i.line <= mem_image[mreq.line_addr];
                end
                delay = $urandom_range(8, 0);
                repeat (delay) @(posedge clk);
                mem_rsp_valid_i <= 1'b1;
                do begin
                    @(negedge clk);
                end while (!mem_rsp_ready_o);
                @(posedge clk);
                mem_rsp_valid_i <= 1'b0;
            end
        end
    end

    initial begin
        rst         = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        started     = 1'b0;
        seen_fill   = 1'b0;
        cur_line    = '0;
        void'($urandom(6506));
        for (int l = 0; l < NUM_LINES; l++) begin
            need_fill[l] = 1'b1;
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem_image[l][w]                   = init_word(l * WORDS_PER_LINE + w);
                model_mem[l * WORDS_PER_LINE + w] = init_word(l * WORDS_PER_LINE + w);
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        walk = 0;
        do begin
            @(negedge clk);
            if (rsp_valid_o || mem_req_valid_o) begin
                abort_run("a valid output went high during the reset walk");
            end
            if (!req_ready_o) begin
                walk++;
            end
        end while (!req_ready_o);
        if (walk < WALK_CYCLES) begin
            abort_run($sformatf("req_ready_o rose after %0d cycles, before the reset walk", walk));
        end

        for (int i = 0; i < NUM_OPS; i++) begin
            req.id    = llc_id_t'(i);
            req.addr  = pick_addr();
            req.wdata = $urandom();
            if (flush_cnt < MAX_FLUSHES && $urandom_range(99, 0) < 4) begin
                req.op = LLC_FLUSH;
            end else if ($urandom_range(1, 0) == 1) begin
                req.op = LLC_WRITE;
            end else begin
                req.op = LLC_READ;
            end
            cur_line  = req.addr.word[ADDR_W-1:OFF_W];
            seen_fill = 1'b0;
            issue_req(req);
            started    = 1'b1;
            exp_rsp.id = req.id;
            case (req.op)
                LLC_WRITE: begin
                    model_mem[req.addr.word] = req.wdata;
                    exp_rsp.rdata            = req.wdata;
                end
                LLC_READ: exp_rsp.rdata = model_mem[req.addr.word];
                default:  exp_rsp.rdata = '0;
            endcase
            take_rsp(got_rsp);
            name = $sformatf("op %0d %s addr %03h", i, req.op.name(), req.addr.word);
            check_rsp(name, exp_rsp, got_rsp);
            if (req.op == LLC_FLUSH) begin
                flush_cnt++;
                for (int l = 0; l < NUM_LINES; l++) begin
                    check_line($sformatf("%s line %03h", name, l), model_line(l), mem_image[l]);
                    need_fill[l] = 1'b1;
                end
            end else begin
                if (need_fill[cur_line] && !seen_fill) begin
                    abort_run($sformatf("%s was served without a memory read of its line", name));
                end
                need_fill[cur_line] = 1'b0;
            end
        end

        repeat (4) @(posedge clk);
        if (rsp_cnt != NUM_OPS) begin
            abort_run($sformatf("%0d responses seen for %0d requests", rsp_cnt, NUM_OPS));
        end else if (wb_cnt == 0) begin
            abort_run("no dirty line was ever written back to memory");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
llc_pkg.sv
llc_localmem.sv
llc_input_decoder.sv
llc_process.sv
llc.sv
llc_sva.sv
llc_tb.sv

/* Bender.yml */
package:
  name: llc

sources:
  - llc_pkg.sv
  - llc_localmem.sv
  - llc_input_decoder.sv
  - llc_process.sv
  - llc.sv
  - target: test
    files:
      - llc_sva.sv
      - llc_tb.sv
